//--- compile.f
source/rs_chien_pkg.sv
source/coef_loader.sv
source/chien_evaluator.sv
source/forney_unit.sv
source/error_corrector.sv
source/rs_chien_top.sv
tb/tb_clock.sv
tb/rs_chien_tb.sv

//--- Makefile
TB_TOP := rs_chien_tb

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TB_TOP) -Mdir obj_dir -o sim

run: build
	obj_dir/sim > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module rs_chien_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- tb/rs_chien_tb.sv
// assertions must be enabled in the simulator; six tests from one fixed seed, stopped by a watchdog
`timescale 1ns/1ps
`default_nettype none

module rs_chien_tb
	import rs_chien_pkg::*;
();

	localparam int coef_count = 35;
	localparam int cycles_per_block = 600;
	localparam int blocks_in_run = 7; // six tests with two blocks in the fifth
	localparam int cycle_limit = cycles_per_block * blocks_in_run;
	localparam int first_valid_cycle = 260; // accepted start to first corrected byte
	localparam int last_valid_cycle = first_valid_cycle + block_length - 1;

	logic clock;
	logic reset;
	logic loc_write;
	logic mag_write;
	coef_index_t coef_index;
	gf_t coef_value;
	count_t locator_degree;
	logic start;
	logic symbol_write;
	position_t symbol_index;
	gf_t symbol_value;
	logic busy;
	logic corrected_valid;
	position_t corrected_index;
	gf_t corrected_value;
	logic block_done;
	logic decoder_fail;
	count_t error_count;

	gf_t exp_table [256];
	int log_table [256];
	gf_t sigma [coef_count];
	gf_t omega [coef_count];
	int sigma_terms;
	int omega_terms;
	gf_t received [block_length];
	gf_t expected_block [block_length];
	logic expected_fail;
	count_t expected_errors;
	int error_positions [$];
	string test_name;
	int failures;
	int failures_before;
	int tests_clean;
	int tests_with_errors;
	position_t next_index;
	int block_valid;
	logic block_start; // marks the one start of a block that must be taken
	int cycles_since_start;
	int cycle_count;

	tb_clock #(
		.period_ns    (8),
		.reset_cycles (2)
	) clock_gen (
		.clock (clock),
		.reset (reset)
	);

	rs_chien_top #(
		.number_of_coefs (coef_count)
	) UUT (
		.clock           (clock),
		.reset           (reset),
		.loc_write       (loc_write),
		.mag_write       (mag_write),
		.coef_index      (coef_index),
		.coef_value      (coef_value),
		.locator_degree  (locator_degree),
		.start           (start),
		.symbol_write    (symbol_write),
		.symbol_index    (symbol_index),
		.symbol_value    (symbol_value),
		.busy            (busy),
		.corrected_valid (corrected_valid),
		.corrected_index (corrected_index),
		.corrected_value (corrected_value),
		.block_done      (block_done),
		.decoder_fail    (decoder_fail),
		.error_count     (error_count)
	);

	// log and antilog tables for alpha = 2 over 0x11D
	task automatic build_tables();
		gf_t value;
		value = 8'd1;
		log_table[0] = 0;
		exp_table[255] = 8'd1;
		for (int e = 0; e < 255; e++)
		begin
			exp_table[e] = value;
			log_table[value] = e;
			value = {value[6:0], 1'b0} ^ (value[7] ? 8'h1d : 8'h00); // times alpha
		end
	endtask

	function automatic gf_t field_mul(gf_t a, gf_t b);
		if (a == '0 || b == '0)
			return '0;
		return exp_table[8'((log_table[a] + log_table[b]) % 255)];
	endfunction

	function automatic gf_t field_div(gf_t a, gf_t b);
		if (a == '0 || b == '0)
			return '0;
		return exp_table[8'((log_table[a] - log_table[b] + 255) % 255)];
	endfunction

	function automatic gf_t alpha_power(int e);
		return exp_table[8'(((e % 255) + 255) % 255)];
	endfunction

	// sigma or omega at x with an optional odd-only sum
	function automatic gf_t eval_poly(logic use_sigma, logic odd_only, gf_t x);
		gf_t sum;
		gf_t power;
		gf_t coef;
		sum = '0;
		power = 8'd1;
		for (int k = 0; k < coef_count; k++)
		begin
			coef = use_sigma ? sigma[k] : omega[k];
			if (!odd_only || (k % 2 == 1))
				sum = sum ^ field_mul(coef, power);
			power = field_mul(power, x);
		end
		return sum;
	endfunction

	task automatic clear_polys();
		for (int k = 0; k < coef_count; k++)
		begin
			sigma[k] = '0;
			omega[k] = '0;
		end
		sigma[0] = 8'd1;
		sigma_terms = 1;
		omega_terms = 1;
	endtask

	// sigma times (1 + alpha^-p x)
	task automatic add_error_factor(input int p);
		gf_t factor;
		factor = alpha_power(-p);
		for (int k = sigma_terms; k > 0; k--)
			sigma[k] = sigma[k] ^ field_mul(factor, sigma[k - 1]);
		sigma_terms++;
	endtask

	task automatic pick_positions(input int how_many);
		int candidate;
		bit taken;
		error_positions.delete();
		while (error_positions.size() < how_many)
		begin
			candidate = int'($urandom_range(254, 0));
			taken = 1'b0;
			foreach (error_positions[n])
				if (error_positions[n] == candidate)
					taken = 1'b1;
			if (!taken)
				error_positions.push_back(candidate);
		end
		foreach (error_positions[n])
			add_error_factor(error_positions[n]);
	endtask

	task automatic fill_received();
		for (int i = 0; i < block_length; i++)
			received[i] = gf_t'($urandom);
	endtask

	// Forney value omega / odd part at every root of sigma
	task automatic predict_block(input count_t declared_degree);
		int roots;
		gf_t x;
		gf_t error_value [block_length];
		roots = 0;
		for (int i = 0; i < block_length; i++)
		begin
			x = alpha_power(i);
			error_value[i] = '0;
			if (eval_poly(1'b1, 1'b0, x) == '0)
			begin
				roots++;
				error_value[i] = field_div(eval_poly(1'b0, 1'b0, x), eval_poly(1'b1, 1'b1, x));
			end
		end
		expected_fail = (roots != int'(declared_degree));
		expected_errors = count_t'(roots);
		for (int i = 0; i < block_length; i++)
			expected_block[i] = expected_fail ? received[i] : received[i] ^ error_value[i];
	endtask

	task automatic write_coefs();
		for (int k = 0; k < sigma_terms; k++)
		begin
			loc_write = 1'b1;
			coef_index = coef_index_t'(k);
			coef_value = sigma[k];
			@(negedge clock);
		end
		loc_write = 1'b0;
		for (int k = 0; k < omega_terms; k++)
		begin
			mag_write = 1'b1;
			coef_index = coef_index_t'(k);
			coef_value = omega[k];
			@(negedge clock);
		end
		mag_write = 1'b0;
	endtask

	// symbols go in during the search; disturb adds start pulses while busy
	task automatic run_block(input count_t declared_degree, input logic disturb);
		write_coefs();
		predict_block(declared_degree);
		locator_degree = declared_degree;
		start = 1'b1;
		block_start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		block_start = 1'b0;
		for (int i = 0; i < block_length; i++)
		begin
			symbol_write = 1'b1;
			symbol_index = position_t'(i);
			symbol_value = received[i];
			start = disturb && (i == 100);
			locator_degree = start ? declared_degree + 6'd1 : declared_degree;
			@(negedge clock);
		end
		symbol_write = 1'b0;
		start = 1'b0;
		locator_degree = declared_degree;
		while (!block_done)
		begin
			start = disturb && corrected_valid && (corrected_index == 8'd40);
			@(negedge clock);
		end
		start = 1'b0;
		repeat (2) @(negedge clock); // busy release is checked here
		if (disturb)
			repeat (first_valid_cycle) @(negedge clock); // a taken pulse would stream by now
	endtask

	task automatic open_test(input string name);
		test_name = name;
		failures_before = failures;
	endtask

	task automatic close_test();
		if (failures == failures_before)
		begin
			tests_clean++;
			$display("%s: ok", test_name);
		end
		else
		begin
			tests_with_errors++;
			$display("%s: %0d mismatches", test_name, failures - failures_before);
		end
	endtask

	always @(posedge clock)
	begin
		if (reset)
		begin
			next_index <= '0;
			block_valid <= 0;
			cycles_since_start <= 0;
		end
		else
		begin
			if (block_start)
				cycles_since_start <= 1;
			else if (cycles_since_start != 0)
				cycles_since_start <= cycles_since_start + 1;
			if (corrected_valid)
				next_index <= (next_index == 8'd254) ? 8'd0 : next_index + 8'd1;
			if (block_done)
				block_valid <= 0;
			else if (corrected_valid)
				block_valid <= block_valid + 1;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		corrected_valid |-> (corrected_value == expected_block[corrected_index]))
		else
		begin
			failures++;
			$display("FAILED %s byte %0d expected %02h actual %02h", test_name,
				$sampled(corrected_index), expected_block[$sampled(corrected_index)],
				$sampled(corrected_value));
		end

	assert property (@(posedge clock) disable iff (reset)
		corrected_valid == ((cycles_since_start >= first_valid_cycle)
			&& (cycles_since_start <= last_valid_cycle)))
		else
		begin
			failures++;
			$display("FAILED %s corrected_valid expected %0b actual %0b", test_name,
				$sampled((cycles_since_start >= first_valid_cycle)
					&& (cycles_since_start <= last_valid_cycle)),
				$sampled(corrected_valid));
		end

	assert property (@(posedge clock) disable iff (reset)
		block_done == (cycles_since_start == last_valid_cycle))
		else
		begin
			failures++;
			$display("FAILED %s block_done expected %0b actual %0b", test_name,
				$sampled(cycles_since_start == last_valid_cycle), $sampled(block_done));
		end

	assert property (@(posedge clock) disable iff (reset)
		busy == ((cycles_since_start >= 1) && (cycles_since_start <= last_valid_cycle)))
		else
		begin
			failures++;
			$display("FAILED %s busy expected %0b actual %0b", test_name,
				$sampled((cycles_since_start >= 1) && (cycles_since_start <= last_valid_cycle)),
				$sampled(busy));
		end

	assert property (@(posedge clock) disable iff (reset)
		corrected_valid |-> (decoder_fail == expected_fail))
		else
		begin
			failures++;
			$display("FAILED %s decoder_fail expected %0b actual %0b", test_name,
				expected_fail, $sampled(decoder_fail));
		end

	assert property (@(posedge clock) disable iff (reset)
		corrected_valid |-> (error_count == expected_errors))
		else
		begin
			failures++;
			$display("FAILED %s error_count expected %0d actual %0d", test_name,
				expected_errors, $sampled(error_count));
		end

	assert property (@(posedge clock) disable iff (reset)
		corrected_valid |-> (corrected_index == next_index))
		else
		begin
			failures++;
			$display("FAILED %s corrected_index expected %0d actual %0d", test_name,
				$sampled(next_index), $sampled(corrected_index));
		end

	assert property (@(posedge clock) disable iff (reset)
		block_done |-> (block_valid == 254))
		else
		begin
			failures++;
			$display("FAILED %s valid bytes expected 255 actual %0d", test_name,
				$sampled(block_valid) + 1);
		end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < cycle_limit)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("run stopped by the watchdog after %0d cycles", cycle_count);
		$display("test failed");
		$finish;
	end

	initial
	begin
		loc_write = 1'b0;
		mag_write = 1'b0;
		coef_index = '0;
		coef_value = '0;
		locator_degree = '0;
		start = 1'b0;
		block_start = 1'b0;
		symbol_write = 1'b0;
		symbol_index = '0;
		symbol_value = '0;
		failures = 0;
		failures_before = 0;
		tests_clean = 0;
		tests_with_errors = 0;
		test_name = "reset";
		expected_fail = 1'b0;
		expected_errors = '0;
		void'($urandom(32'hafd3_2e9b)); // one seed for the whole run
		build_tables();
		@(negedge clock);
		while (reset)
			@(negedge clock);

		open_test("error_free");
		clear_polys();
		fill_received();
		run_block(6'd0, 1'b0);
		close_test();

		open_test("single_error");
		clear_polys();
		pick_positions(1);
		omega[0] = gf_t'($urandom_range(255, 1));
		fill_received();
		run_block(6'd1, 1'b0);
		close_test();

		open_test("three_errors");
		clear_polys();
		pick_positions(3);
		for (int k = 0; k < 3; k++)
			omega[k] = gf_t'($urandom);
		omega_terms = 3;
		fill_received();
		run_block(6'd3, 1'b0);
		close_test();

		open_test("degree_mismatch");
		clear_polys();
		pick_positions(1);
		omega[0] = gf_t'($urandom_range(255, 1));
		fill_received();
		run_block(6'd2, 1'b0); // one root against degree 2
		close_test();

		open_test("bank_clearing");
		clear_polys();
		pick_positions(8);
		for (int k = 0; k < coef_count; k++)
			omega[k] = gf_t'($urandom);
		omega_terms = coef_count; // fills the whole magnitude bank
		fill_received();
		run_block(6'd8, 1'b0);
		clear_polys();
		pick_positions(1);
		omega[0] = gf_t'($urandom_range(255, 1));
		fill_received();
		run_block(6'd1, 1'b0);
		close_test();

		open_test("start_while_busy");
		clear_polys();
		pick_positions(1);
		omega[0] = gf_t'($urandom_range(255, 1));
		fill_received();
		run_block(6'd1, 1'b1);
		close_test();

		$display("%0d tests, %0d clean, %0d with mismatches, %0d checks failed",
			tests_clean + tests_with_errors, tests_clean, tests_with_errors, failures);
		if (failures == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
// free-running clock from time zero; reset starts high and drops on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
	parameter int period_ns = 8,
	parameter int reset_cycles = 2
)
(
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever
			#(period_ns / 2.0) clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(negedge clock);
		reset <= 1'b0; // seen low from the next falling edge on
	end

endmodule

`default_nettype wire

//--- source/rs_chien_top.sv
// number_of_coefs from 2 to 64; first corrected byte 260 cycles after an accepted start
`timescale 1ns/1ps
`default_nettype none

module rs_chien_top
	import rs_chien_pkg::*;
#(
	parameter int number_of_coefs = 35
)
(
	input  logic        clock,
	input  logic        reset,
	input  logic        loc_write,
	input  logic        mag_write,
	input  coef_index_t coef_index,
	input  gf_t         coef_value,
	input  count_t      locator_degree,
	input  logic        start,
	input  logic        symbol_write,
	input  position_t   symbol_index,
	input  gf_t         symbol_value,
	output logic        busy,
	output logic        corrected_valid,
	output position_t   corrected_index,
	output gf_t         corrected_value,
	output logic        block_done,
	output logic        decoder_fail,
	output count_t      error_count
);

	logic load;
	gf_t loc_coefs [number_of_coefs];
	gf_t mag_coefs [number_of_coefs];
	count_t degree;
	logic eval_valid;
	logic root;
	position_t eval_position;
	gf_t odd_value;
	gf_t omega_value;
	logic search_done;
	count_t root_count;
	logic store_write;
	position_t store_index;
	gf_t store_value;

	coef_loader #(
		.number_of_coefs (number_of_coefs)
	) loader (
		.clock          (clock),
		.reset          (reset),
		.loc_write      (loc_write),
		.mag_write      (mag_write),
		.coef_index     (coef_index),
		.coef_value     (coef_value),
		.locator_degree (locator_degree),
		.start          (start),
		.block_done     (block_done),
		.busy           (busy),
		.load           (load),
		.loc_coefs      (loc_coefs),
		.mag_coefs      (mag_coefs),
		.degree         (degree)
	);

	chien_evaluator #(
		.number_of_coefs (number_of_coefs)
	) chien (
		.clock         (clock),
		.reset         (reset),
		.load          (load),
		.loc_coefs     (loc_coefs),
		.mag_coefs     (mag_coefs),
		.eval_valid    (eval_valid),
		.root          (root),
		.eval_position (eval_position),
		.odd_value     (odd_value),
		.omega_value   (omega_value),
		.search_done   (search_done),
		.root_count    (root_count)
	);

	forney_unit forney (
		.clock         (clock),
		.reset         (reset),
		.eval_valid    (eval_valid),
		.root          (root),
		.eval_position (eval_position),
		.odd_value     (odd_value),
		.omega_value   (omega_value),
		.store_write   (store_write),
		.store_index   (store_index),
		.store_value   (store_value)
	);

	error_corrector corrector (
		.clock           (clock),
		.reset           (reset),
		.symbol_write    (symbol_write),
		.symbol_index    (symbol_index),
		.symbol_value    (symbol_value),
		.store_write     (store_write),
		.store_index     (store_index),
		.store_value     (store_value),
		.search_done     (search_done),
		.root_count      (root_count),
		.degree          (degree),
		.corrected_valid (corrected_valid),
		.block_done      (block_done),
		.decoder_fail    (decoder_fail),
		.corrected_index (corrected_index),
		.corrected_value (corrected_value),
		.error_count     (error_count)
	);

endmodule

`default_nettype wire

//--- source/error_corrector.sv
// received bytes must be written before search_done; output cannot be stalled once it starts
`timescale 1ns/1ps
`default_nettype none

module error_corrector
	import rs_chien_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      symbol_write,
	input  position_t symbol_index,
	input  gf_t       symbol_value,
	input  logic      store_write,
	input  position_t store_index,
	input  gf_t       store_value,
	input  logic      search_done,
	input  count_t    root_count,
	input  count_t    degree,
	output logic      corrected_valid,
	output logic      block_done,
	output logic      decoder_fail,
	output position_t corrected_index,
	output gf_t       corrected_value,
	output count_t    error_count
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait_store,
		st_decide,
		st_stream
	} corr_state_t;

	localparam position_t last_position = position_t'(block_length - 1);

	corr_state_t state;
	gf_t rx_buffer [block_length];
	gf_t err_store [block_length];
	count_t count_q;
	position_t read_pos;
	position_t out_pos;
	logic counts_match;
	logic use_store;

	assign counts_match = (count_q == degree);
	assign out_pos = (state == st_decide) ? '0 : read_pos;
	assign use_store = (state == st_decide) ? counts_match : !decoder_fail;

	always_ff @(posedge clock)
	begin
		if (symbol_write)
			rx_buffer[symbol_index] <= symbol_value;
		if (store_write)
			err_store[store_index] <= store_value;
		corrected_value <= rx_buffer[out_pos] ^ (use_store ? err_store[out_pos] : '0);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= st_idle;
			count_q <= '0;
			read_pos <= '0;
			corrected_valid <= 1'b0;
			corrected_index <= '0;
			block_done <= 1'b0;
			decoder_fail <= 1'b0;
			error_count <= '0;
		end
		else
		begin
			corrected_valid <= 1'b0;
			block_done <= 1'b0;
			case (state)
				st_idle:
					if (search_done)
					begin
						count_q <= root_count;
						state <= st_wait_store;
					end
				st_wait_store:
					if (store_write && store_index == last_position)
						state <= st_decide; // store complete after this write
				st_decide:
				begin
					decoder_fail <= !counts_match;
					error_count <= count_q;
					corrected_valid <= 1'b1;
					corrected_index <= '0;
					read_pos <= position_t'(1);
					state <= st_stream;
				end
				st_stream:
				begin
					corrected_valid <= 1'b1;
					corrected_index <= read_pos;
					read_pos <= read_pos + 1'b1;
					if (read_pos == last_position)
					begin
						block_done <= 1'b1;
						state <= st_idle;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		symbol_write |-> (int'(symbol_index) < block_length))
		else $error("symbol index %0d beyond block", symbol_index);

endmodule

`default_nettype wire

//--- source/forney_unit.sv
// fixed two-cycle latency, no stall; value is zero at non-root positions
`timescale 1ns/1ps
`default_nettype none

module forney_unit
	import rs_chien_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      eval_valid,
	input  logic      root,
	input  position_t eval_position,
	input  gf_t       odd_value,
	input  gf_t       omega_value,
	output logic      store_write,
	output position_t store_index,
	output gf_t       store_value
);

	logic s1_valid;
	logic s1_root;
	position_t s1_position;
	gf_t s1_inverse;
	gf_t s1_omega;

	// stage 1: invert the odd part
	always_ff @(posedge clock)
	begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= eval_valid;
	end

	always_ff @(posedge clock)
	begin
		s1_root <= root;
		s1_position <= eval_position;
		s1_inverse <= gf_inv(odd_value);
		s1_omega <= omega_value;
	end

	// stage 2: omega / odd part
	always_ff @(posedge clock)
	begin
		if (reset)
			store_write <= 1'b0;
		else
			store_write <= s1_valid;
	end

	always_ff @(posedge clock)
	begin
		store_index <= s1_position;
		if (s1_root)
			store_value <= gf_mul(s1_inverse, s1_omega);
		else
			store_value <= '0; // no error here
	end

	// a root with zero odd part means a repeated root
	assert property (@(posedge clock) disable iff (reset)
		(eval_valid && root) |-> (odd_value != '0))
		else $error("root at position %0d with zero odd part", eval_position);

endmodule

`default_nettype wire

//--- source/chien_evaluator.sv
// one position per cycle for 255 cycles after load; a new load must wait until search_done
`timescale 1ns/1ps
`default_nettype none

module chien_evaluator
	import rs_chien_pkg::*;
#(
	parameter int number_of_coefs = 35
)
(
	input  logic      clock,
	input  logic      reset,
	input  logic      load,
	input  gf_t       loc_coefs [number_of_coefs],
	input  gf_t       mag_coefs [number_of_coefs],
	output logic      eval_valid,
	output logic      root,
	output position_t eval_position,
	output gf_t       odd_value,
	output gf_t       omega_value,
	output logic      search_done,
	output count_t    root_count
);

	typedef enum logic {
		chien_idle,
		chien_search
	} chien_state_t;

	localparam position_t last_position = position_t'(block_length - 1);

	chien_state_t state;
	position_t step;
	gf_t loc_work [number_of_coefs]; // sigma_k * alpha^(k*i)
	gf_t mag_work [number_of_coefs]; // omega_k * alpha^(k*i)
	gf_t even_sum;
	gf_t odd_sum;
	gf_t omega_sum;

	always_comb
	begin
		even_sum = '0;
		odd_sum = '0;
		omega_sum = '0;
		for (int k = 0; k < number_of_coefs; k++)
		begin
			if (k % 2 == 0)
				even_sum = even_sum ^ loc_work[k];
			else
				odd_sum = odd_sum ^ loc_work[k];
			omega_sum = omega_sum ^ mag_work[k];
		end
	end

	assign eval_valid = (state == chien_search);
	assign eval_position = step;
	assign root = eval_valid && (even_sum == odd_sum); // sigma(alpha^i) == 0
	assign odd_value = odd_sum;
	assign omega_value = omega_sum;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= chien_idle;
			step <= '0;
			search_done <= 1'b0;
			root_count <= '0;
		end
		else
		begin
			search_done <= 1'b0;
			if (load)
			begin
				state <= chien_search;
				step <= '0;
				root_count <= '0;
			end
			else if (state == chien_search)
			begin
				if (root)
					root_count <= root_count + 1'b1;
				step <= step + 1'b1;
				if (step == last_position)
				begin
					state <= chien_idle;
					search_done <= 1'b1; // count is final next cycle
				end
			end
		end
	end

	// working copies advance by the constant alpha^k every step
	always_ff @(posedge clock)
	begin
		for (int k = 0; k < number_of_coefs; k++)
		begin
			if (load)
			begin
				loc_work[k] <= loc_coefs[k];
				mag_work[k] <= mag_coefs[k];
			end
			else if (state == chien_search)
			begin
				loc_work[k] <= gf_mul(loc_work[k], gf_pow_alpha(k));
				mag_work[k] <= gf_mul(mag_work[k], gf_pow_alpha(k));
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		load |-> (state == chien_idle))
		else $error("load arrived during a running search");

endmodule

`default_nettype wire

//--- source/coef_loader.sv
// banks read as zero after reset and after each handover; a write in the load cycle lands in the next block
`timescale 1ns/1ps
`default_nettype none

module coef_loader
	import rs_chien_pkg::*;
#(
	parameter int number_of_coefs = 35
)
(
	input  logic        clock,
	input  logic        reset,
	input  logic        loc_write,
	input  logic        mag_write,
	input  coef_index_t coef_index,
	input  gf_t         coef_value,
	input  count_t      locator_degree,
	input  logic        start,
	input  logic        block_done,
	output logic        busy,
	output logic        load,
	output gf_t         loc_coefs [number_of_coefs],
	output gf_t         mag_coefs [number_of_coefs],
	output count_t      degree
);

	gf_t loc_bank [number_of_coefs];
	gf_t mag_bank [number_of_coefs];
	logic accept;

	assign accept = start && !busy; // start is dropped while a block is in flight

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			load <= 1'b0;
			degree <= '0;
		end
		else
		begin
			load <= accept;
			if (accept)
			begin
				busy <= 1'b1;
				degree <= locator_degree; // held until the next accepted start
			end
			else if (block_done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset || load)
		begin
			for (int k = 0; k < number_of_coefs; k++)
			begin
				loc_bank[k] <= '0;
				mag_bank[k] <= '0;
			end
		end
		if (!reset && loc_write)
			loc_bank[coef_index] <= coef_value;
		if (!reset && mag_write)
			mag_bank[coef_index] <= coef_value;
	end

	assign loc_coefs = loc_bank;
	assign mag_coefs = mag_bank;

	assert property (@(posedge clock) disable iff (reset)
		(loc_write || mag_write) |-> (int'(coef_index) < number_of_coefs))
		else $error("coefficient index %0d out of range", coef_index);

endmodule

`default_nettype wire

//--- source/rs_chien_pkg.sv
// GF(2^8) over 0x11D with alpha = 2; functions are combinational and meant for constant or narrow use
`default_nettype none

package rs_chien_pkg;

	typedef logic [7:0] gf_t;         // one field symbol
	typedef logic [7:0] position_t;   // codeword position 0..254
	typedef logic [5:0] coef_index_t; // polynomial coefficient index
	typedef logic [5:0] count_t;      // root count or locator degree

	localparam int block_length = 255;
	localparam logic [8:0] field_polynomial = 9'h11D;

	// shift-and-add multiply with reduction after every shift
	function automatic gf_t gf_mul(gf_t a, gf_t b);
		logic [8:0] shifted;
		gf_t product;
		product = '0;
		shifted = {1'b0, a};
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				product = product ^ shifted[7:0];
			shifted = shifted << 1;
			if (shifted[8])
				shifted = shifted ^ field_polynomial; // reduce back to 8 bits
		end
		return product;
	endfunction

	// x^254 = x^2 * x^4 * ... * x^128, zero maps to zero
	function automatic gf_t gf_inv(gf_t x);
		gf_t square;
		gf_t result;
		square = x;
		result = 8'd1;
		for (int i = 0; i < 7; i++)
		begin
			square = gf_mul(square, square);
			result = gf_mul(result, square);
		end
		return result;
	endfunction

	function automatic gf_t gf_pow_alpha(int unsigned exponent);
		gf_t result;
		result = 8'd1;
		for (int unsigned i = 0; i < exponent % 255; i++)
			result = gf_mul(result, 8'd2); // alpha is 2
		return result;
	endfunction

endpackage

`default_nettype wire
